// File: Makefile
VERILATOR ?= verilator
TOP       ?= spi_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
src/spi_cfg_pkg.sv
src/spi_cmd_pkg.sv
src/spi_stream_fifo.sv
src/spi_mosi_serializer.sv
src/spi_miso_deserializer.sv
src/spi_engine.sv
src/spi_fifo_engine.sv
verif/spi_props.sv
verif/spi_tb.sv

// File: src/spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

    // Data path geometry
    localparam int DATA_WIDTH = 32;

    // Width of the csn bus
    localparam int SEL_WIDTH_MAX = 8;

    // Select decode modes
    localparam int SEL_ONEHOT = 0;
    localparam int SEL_BINARY = 1;

    // Enough to hold a length of 32
    localparam int XFER_LEN_WIDTH = 6;

endpackage

`default_nettype wire

// File: src/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

    import spi_cfg_pkg::*;

    typedef logic [2:0] device_t;
    typedef logic [XFER_LEN_WIDTH-1:0] xfer_len_t;

    // Cycle counts for SCLK half period and guard delays
    typedef logic [7:0] wait_t;

    // One SPI transaction, MSB first in field order
    typedef struct packed {
        device_t   device;
        logic      cpol;
        logic      cpha;
        xfer_len_t xfer_len;
        wait_t     sclk_cycles;
        wait_t     wait_start;
        wait_t     csn_to_sclk;
        wait_t     sclk_to_csn;
    } spi_cmd_t;

    // Single bit on the shift streams
    typedef struct packed {
        logic value;
    } spi_bit_t;

endpackage

`default_nettype wire

// File: src/spi_engine.sv
`default_nettype none

module spi_engine import spi_cfg_pkg::*, spi_cmd_pkg::*; #(
    parameter int SEL_MODE  = SEL_ONEHOT,
    parameter int SEL_WIDTH = SEL_WIDTH_MAX
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  spi_cmd_t             cmd_data,
    input  logic                 mosi_empty,
    input  logic                 tx_bit_valid,
    output logic                 tx_bit_ready,
    input  spi_bit_t             tx_bit,
    output logic                 rx_bit_valid,
    input  logic                 rx_bit_ready,
    output spi_bit_t             rx_bit,
    output logic                 cmd_completed,
    output logic                 engine_busy,
    output logic                 sclk,
    output logic                 mosi,
    input  logic                 miso,
    output logic [SEL_WIDTH-1:0] csn,
    output logic                 sel_active
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_BEGIN,
        SELECT,
        LATCH,
        SHIFT,
        DESELECT,
        WAIT_END,
        END
    } state_t;

    state_t state;
    spi_cmd_t cur_cmd;
    wait_t timer;
    wait_t sclk_cnt;
    logic [XFER_LEN_WIDTH:0] edges_left;
    logic sclk_gen;
    logic trigger;
    logic cmd_accept;
    logic edge_due;
    logic edge_sample;
    logic sclk_hold;
    logic edge_fire;

    function automatic logic [SEL_WIDTH-1:0] gen_sel(input device_t dev);
        logic [SEL_WIDTH-1:0] sel;
        if (SEL_MODE == SEL_BINARY) begin
            sel = SEL_WIDTH'(dev);
        end else begin
            sel = SEL_WIDTH'(1) << dev;
        end
        return sel;
    endfunction

    function automatic wait_t dec_sat(input wait_t w);
        return (w == '0) ? '0 : w - 1'b1;
    endfunction

    assign sclk          = sclk_gen ^ cur_cmd.cpol;
    assign mosi          = tx_bit.value;
    assign trigger       = (timer == '0);
    assign cmd_accept    = cmd_valid & cmd_ready;
    assign cmd_completed = (state == END);
    assign engine_busy   = (state != IDLE);

    //////////////////////////////
    // Edge scheduling
    //////////////////////////////

    // SELECT runs the first edge, sample type when cpha is 0
    always_comb begin
        edge_due    = 1'b0;
        edge_sample = 1'b0;
        case (state)
            SELECT: begin
                edge_due    = trigger;
                edge_sample = ~cur_cmd.cpha;
            end
            LATCH: begin
                edge_due    = (sclk_cnt == '0);
                edge_sample = 1'b1;
            end
            SHIFT: begin
                edge_due = (sclk_cnt == '0);
            end
            default: begin
            end
        endcase
    end

    assign tx_bit_ready = edge_due & (state == SHIFT);

    // Stretch SCLK on a late tx bit or a refused rx bit
    assign sclk_hold = edge_sample ? (rx_bit_valid & ~rx_bit_ready)
                                   : (tx_bit_ready & ~tx_bit_valid);
    assign edge_fire = edge_due & ~sclk_hold;

    //////////////////////////////
    // Sequencer
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state        <= IDLE;
            cmd_ready    <= 1'b0;
            cur_cmd      <= '0;
            timer        <= '0;
            sclk_cnt     <= '0;
            edges_left   <= '0;
            sclk_gen     <= 1'b0;
            rx_bit_valid <= 1'b0;
            csn          <= '0;
            sel_active   <= 1'b0;
        end else begin
            if (rx_bit_valid && rx_bit_ready) begin
                rx_bit_valid <= 1'b0;
            end
            if (timer != '0) begin
                timer <= timer - 1'b1;
            end

            case (state)
                IDLE: begin
                    sclk_gen <= 1'b0;
                    if (cmd_accept) begin
                        cmd_ready  <= 1'b0;
                        cur_cmd    <= cmd_data;
                        timer      <= cmd_data.wait_start;
                        edges_left <= {cmd_data.xfer_len, 1'b0};
                        state      <= WAIT_BEGIN;
                    end else begin
                        cmd_ready <= ~mosi_empty & rx_bit_ready;
                    end
                end
                WAIT_BEGIN: begin
                    if (trigger) begin
                        csn        <= gen_sel(cur_cmd.device);
                        sel_active <= 1'b1;
                        timer      <= dec_sat(cur_cmd.csn_to_sclk);
                        state      <= SELECT;
                    end
                end
                LATCH, SHIFT: begin
                    if (sclk_cnt != '0) begin
                        sclk_cnt <= sclk_cnt - 1'b1;
                    end
                end
                DESELECT: begin
                    // Last rx bit must be taken before align
                    if (trigger && (!rx_bit_valid || rx_bit_ready)) begin
                        csn        <= '0;
                        sel_active <= 1'b0;
                        state      <= WAIT_END;
                    end
                end
                WAIT_END: begin
                    state <= END;
                end
                END: begin
                    state <= IDLE;
                end
                default: begin
                end
            endcase

            if (edge_fire) begin
                sclk_gen   <= ~sclk_gen;
                sclk_cnt   <= cur_cmd.sclk_cycles;
                edges_left <= edges_left - 1'b1;
                if (edge_sample) begin
                    rx_bit_valid <= 1'b1;
                end
                if (edges_left <= 1) begin
                    timer <= dec_sat(cur_cmd.sclk_to_csn);
                    state <= DESELECT;
                end else if (edge_sample) begin
                    state <= SHIFT;
                end else begin
                    state <= LATCH;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (edge_fire && edge_sample) begin
            rx_bit.value <= miso;
        end
    end

endmodule

`default_nettype wire

// File: src/spi_fifo_engine.sv
`default_nettype none

module spi_fifo_engine import spi_cfg_pkg::*, spi_cmd_pkg::*; #(
    parameter int SEL_MODE   = SEL_ONEHOT,
    parameter int SEL_WIDTH  = SEL_WIDTH_MAX,
    parameter int CMD_DEPTH  = 16,
    parameter int DATA_DEPTH = 64
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  spi_cmd_t              cmd_data,
    input  logic                  mosi_valid,
    output logic                  mosi_ready,
    input  logic [DATA_WIDTH-1:0] mosi_data,
    output logic                  miso_valid,
    input  logic                  miso_ready,
    output logic [DATA_WIDTH-1:0] miso_data,
    output logic                  cmd_completed,
    output logic                  engine_busy,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso,
    output logic [SEL_WIDTH-1:0]  csn,
    output logic                  sel_active
);

    typedef logic [DATA_WIDTH-1:0] data_word_t;

    // Command FIFO to engine
    logic     f2e_cmd_valid;
    logic     f2e_cmd_ready;
    spi_cmd_t f2e_cmd_data;

    // MOSI FIFO to serializer
    logic       f2s_valid;
    logic       f2s_ready;
    data_word_t f2s_data;

    // Deserializer to MISO FIFO
    logic       d2f_valid;
    logic       d2f_ready;
    data_word_t d2f_data;

    // Bit streams around the engine
    logic     tx_bit_valid;
    logic     tx_bit_ready;
    spi_bit_t tx_bit;
    logic     rx_bit_valid;
    logic     rx_bit_ready;
    spi_bit_t rx_bit;
    logic     mosi_empty;

    spi_stream_fifo #(
        .payload_t(spi_cmd_t),
        .DEPTH(CMD_DEPTH)
    ) cmd_fifo (
        .clk(clk),
        .rstn(rstn),
        .in_valid(cmd_valid),
        .in_ready(cmd_ready),
        .in_data(cmd_data),
        .out_valid(f2e_cmd_valid),
        .out_ready(f2e_cmd_ready),
        .out_data(f2e_cmd_data)
    );

    spi_stream_fifo #(
        .payload_t(data_word_t),
        .DEPTH(DATA_DEPTH)
    ) mosi_fifo (
        .clk(clk),
        .rstn(rstn),
        .in_valid(mosi_valid),
        .in_ready(mosi_ready),
        .in_data(mosi_data),
        .out_valid(f2s_valid),
        .out_ready(f2s_ready),
        .out_data(f2s_data)
    );

    spi_stream_fifo #(
        .payload_t(data_word_t),
        .DEPTH(DATA_DEPTH)
    ) miso_fifo (
        .clk(clk),
        .rstn(rstn),
        .in_valid(d2f_valid),
        .in_ready(d2f_ready),
        .in_data(d2f_data),
        .out_valid(miso_valid),
        .out_ready(miso_ready),
        .out_data(miso_data)
    );

    spi_mosi_serializer mosi_shift (
        .clk(clk),
        .rstn(rstn),
        .word_valid(f2s_valid),
        .word_ready(f2s_ready),
        .word_data(f2s_data),
        .bit_valid(tx_bit_valid),
        .bit_ready(tx_bit_ready),
        .bit_data(tx_bit),
        .align(cmd_completed),
        .empty(mosi_empty)
    );

    spi_miso_deserializer miso_shift (
        .clk(clk),
        .rstn(rstn),
        .bit_valid(rx_bit_valid),
        .bit_ready(rx_bit_ready),
        .bit_data(rx_bit),
        .word_valid(d2f_valid),
        .word_ready(d2f_ready),
        .word_data(d2f_data),
        .align(cmd_completed)
    );

    spi_engine #(
        .SEL_MODE(SEL_MODE),
        .SEL_WIDTH(SEL_WIDTH)
    ) engine (
        .clk(clk),
        .rstn(rstn),
        .cmd_valid(f2e_cmd_valid),
        .cmd_ready(f2e_cmd_ready),
        .cmd_data(f2e_cmd_data),
        .mosi_empty(mosi_empty),
        .tx_bit_valid(tx_bit_valid),
        .tx_bit_ready(tx_bit_ready),
        .tx_bit(tx_bit),
        .rx_bit_valid(rx_bit_valid),
        .rx_bit_ready(rx_bit_ready),
        .rx_bit(rx_bit),
        .cmd_completed(cmd_completed),
        .engine_busy(engine_busy),
        .sclk(sclk),
        .mosi(mosi),
        .miso(miso),
        .csn(csn),
        .sel_active(sel_active)
    );

endmodule

`default_nettype wire

// File: src/spi_miso_deserializer.sv
`default_nettype none

module spi_miso_deserializer import spi_cfg_pkg::*, spi_cmd_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  bit_valid,
    output logic                  bit_ready,
    input  spi_bit_t              bit_data,
    output logic                  word_valid,
    input  logic                  word_ready,
    output logic [DATA_WIDTH-1:0] word_data,
    input  logic                  align
);

    logic [DATA_WIDTH-1:0] shreg;
    logic pending;

    // No new bits until the gathered word leaves
    assign bit_ready  = ~pending;
    assign word_valid = pending;
    assign word_data  = shreg;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pending <= 1'b0;
            shreg   <= '0;
        end else if (word_valid && word_ready) begin
            pending <= 1'b0;
            shreg   <= '0;
        end else begin
            if (bit_valid && bit_ready) begin
                shreg <= {shreg[DATA_WIDTH-2:0], bit_data.value};
            end
            if (align) begin
                pending <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/spi_mosi_serializer.sv
`default_nettype none

module spi_mosi_serializer import spi_cfg_pkg::*, spi_cmd_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  word_valid,
    output logic                  word_ready,
    input  logic [DATA_WIDTH-1:0] word_data,
    output logic                  bit_valid,
    input  logic                  bit_ready,
    output spi_bit_t              bit_data,
    input  logic                  align,
    output logic                  empty
);

    logic [DATA_WIDTH-1:0] shreg;
    logic staged;

    assign empty          = ~staged;
    assign word_ready     = ~staged;
    assign bit_valid      = staged;
    assign bit_data.value = shreg[DATA_WIDTH-1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            staged <= 1'b0;
        end else if (word_valid && word_ready) begin
            staged <= 1'b1;
        end else if (align) begin
            // Rest of the word is dropped
            staged <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid && word_ready) begin
            shreg <= word_data;
        end else if (bit_valid && bit_ready) begin
            shreg <= {shreg[DATA_WIDTH-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: src/spi_stream_fifo.sv
`default_nettype none

module spi_stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 16
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count_next;
            // Registered full flag
            in_ready <= (count_next != CNT_W'(DEPTH));
        end
    end

endmodule

`default_nettype wire

// File: verif/spi_input.txt
# device cpol cpha xfer_len sclk_cycles wait_start csn_to_sclk sclk_to_csn (decimal)
# then mosi_word expected_miso expected_csn (hex)
0 0 0 8  1 2 1 1 a5c30f1e 000000a5 01
1 0 1 16 0 0 0 0 12345678 00001234 02
2 1 0 32 2 3 2 2 deadbeef deadbeef 04
3 1 1 1  0 1 0 0 80000001 00000001 08
4 0 0 5  1 0 1 1 b0000000 00000016 10
5 0 1 12 3 2 3 0 c0ffee00 00000c0f 20
6 1 0 24 0 0 0 3 13579bdf 0013579b 40
7 1 1 20 1 4 1 1 2468ace0 0002468a 80
0 0 0 32 0 0 0 0 0f0ff0f0 0f0ff0f0 01
2 0 1 31 0 1 0 1 fffffffe 7fffffff 04
1 1 0 13 1 0 2 0 9a500000 0000134a 02
3 1 1 4  2 2 0 2 60000000 00000006 08
5 0 0 16 0 0 0 0 faceb00c 0000face 20
6 1 0 28 0 1 1 0 01234567 00123456 40
4 0 1 9  1 0 0 1 55800000 000000ab 10
7 1 1 32 0 0 0 0 87654321 87654321 80

// File: verif/spi_props.sv
`default_nettype none

module spi_props import spi_cfg_pkg::*, spi_cmd_pkg::*; #(
    parameter int SEL_WIDTH = SEL_WIDTH_MAX
) (
    input logic                 clk,
    input logic                 rstn,
    input logic                 cmd_valid,
    input logic                 cmd_ready,
    input logic                 engine_busy,
    input logic                 cmd_completed,
    input logic                 sel_active,
    input logic [SEL_WIDTH-1:0] csn,
    input logic                 sclk,
    input spi_cmd_t             cur_cmd
);

    // No device selected outside a transfer
    csn_idle: assert property (@(posedge clk) disable iff (!rstn)
        !sel_active |-> (csn == '0))
        else $error("csn is not zero while sel_active is low");

    done_pulse: assert property (@(posedge clk) disable iff (!rstn)
        cmd_completed |=> !cmd_completed)
        else $error("cmd_completed stayed high for more than one cycle");

    // SCLK rests at its polarity between transfers
    sclk_rest: assert property (@(posedge clk) disable iff (!rstn)
        !sel_active |-> (sclk == cur_cmd.cpol))
        else $error("sclk differs from cpol while no edges are running");

    busy_no_accept: assert property (@(posedge clk) disable iff (!rstn)
        engine_busy |-> !(cmd_valid && cmd_ready))
        else $error("command accepted while the engine is busy");

endmodule

bind spi_engine spi_props #(
    .SEL_WIDTH(SEL_WIDTH)
) props_i (
    .clk(clk),
    .rstn(rstn),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .engine_busy(engine_busy),
    .cmd_completed(cmd_completed),
    .sel_active(sel_active),
    .csn(csn),
    .sclk(sclk),
    .cur_cmd(cur_cmd)
);

`default_nettype wire

// File: verif/spi_tb.sv
`default_nettype none

module spi_tb import spi_cfg_pkg::*, spi_cmd_pkg::*; ();

    localparam int SEL_WIDTH = 8;
    localparam int TIMEOUT   = 5000;

    logic                  clk;
    logic                  rstn;
    logic                  cmd_valid;
    logic                  cmd_ready;
    spi_cmd_t              cmd_data;
    logic                  mosi_valid;
    logic                  mosi_ready;
    logic [DATA_WIDTH-1:0] mosi_data;
    logic                  miso_valid;
    logic                  miso_ready;
    logic [DATA_WIDTH-1:0] miso_data;
    logic                  cmd_completed;
    logic                  engine_busy;
    logic                  sclk;
    logic                  loop_line;
    logic [SEL_WIDTH-1:0]  csn;
    logic                  sel_active;

    spi_cmd_t              cmds[$];
    logic [DATA_WIDTH-1:0] tx_words[$];
    logic [DATA_WIDTH-1:0] exp_words[$];
    logic [SEL_WIDTH-1:0]  exp_sels[$];
    int                    test_errs[$];
    int                    n_tests;
    int                    errors;
    int                    done_cnt;
    int                    edge_cnt;
    logic                  prev_sclk;

    // MOSI looped straight back into MISO
    spi_fifo_engine #(
        .SEL_MODE(SEL_ONEHOT),
        .SEL_WIDTH(SEL_WIDTH),
        .CMD_DEPTH(4),
        .DATA_DEPTH(2)
    ) spi_fifo_engine_i (
        .clk(clk),
        .rstn(rstn),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_data(cmd_data),
        .mosi_valid(mosi_valid),
        .mosi_ready(mosi_ready),
        .mosi_data(mosi_data),
        .miso_valid(miso_valid),
        .miso_ready(miso_ready),
        .miso_data(miso_data),
        .cmd_completed(cmd_completed),
        .engine_busy(engine_busy),
        .sclk(sclk),
        .mosi(loop_line),
        .miso(loop_line),
        .csn(csn),
        .sel_active(sel_active)
    );

    always #10 clk = ~clk;

    // Random back-pressure on the response stream
    always @(posedge clk) begin
        #2;
        if (rstn) begin
            miso_ready = (($urandom % 4) == 0);
        end
    end

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        $display("Verification failed");
        $finish;
    endtask

    task automatic note_error(input int k);
        errors++;
        test_errs[k]++;
    endtask

    // Top len bits of the word shifted down to bit 0
    function automatic logic [DATA_WIDTH-1:0] top_bits(input logic [DATA_WIDTH-1:0] w,
                                                       input int len);
        return w >> (DATA_WIDTH - len);
    endfunction

    task automatic load_tests();
        int                    fd;
        int                    n;
        int                    f[8];
        logic [DATA_WIDTH-1:0] tx;
        logic [DATA_WIDTH-1:0] rx;
        logic [SEL_WIDTH-1:0]  sel;
        string                 line;
        spi_cmd_t              c;
        fd = $fopen("verif/spi_input.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verif/spi_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 0 || line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], tx, rx, sel);
            if (n != 11) begin
                continue;
            end
            if (f[3] < 1 || f[3] > DATA_WIDTH) begin
                abort_run("transfer length out of range in verif/spi_input.txt");
            end
            assert (sel == (SEL_WIDTH'(1) << f[0])) else begin
                $display("Error: expected csn in the data file does not match device %0d", f[0]);
                errors++;
            end
            c.device      = device_t'(f[0]);
            c.cpol        = (f[1] != 0);
            c.cpha        = (f[2] != 0);
            c.xfer_len    = xfer_len_t'(f[3]);
            c.sclk_cycles = wait_t'(f[4]);
            c.wait_start  = wait_t'(f[5]);
            c.csn_to_sclk = wait_t'(f[6]);
            c.sclk_to_csn = wait_t'(f[7]);
            cmds.push_back(c);
            tx_words.push_back(tx);
            exp_words.push_back(rx);
            exp_sels.push_back(sel);
            test_errs.push_back(0);
        end
        $fclose(fd);
        n_tests = cmds.size();
    endtask

    task automatic send_cmd(input spi_cmd_t c);
        int waited;
        waited    = 0;
        cmd_data  = c;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            if (waited == TIMEOUT) begin
                abort_run("timeout waiting for cmd_ready");
            end
            @(posedge clk);
            #2;
            waited++;
        end
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic send_word(input logic [DATA_WIDTH-1:0] w);
        int waited;
        waited     = 0;
        mosi_data  = w;
        mosi_valid = 1'b1;
        while (!mosi_ready) begin
            if (waited == TIMEOUT) begin
                abort_run("timeout waiting for mosi_ready");
            end
            @(posedge clk);
            #2;
            waited++;
        end
        @(posedge clk);
        #2;
        mosi_valid = 1'b0;
    endtask

    task automatic drive_cmds();
        for (int k = 0; k < n_tests; k++) begin
            send_cmd(cmds[k]);
        end
    endtask

    task automatic drive_words();
        for (int k = 0; k < n_tests; k++) begin
            send_word(tx_words[k]);
        end
    endtask

    //////////////////////////////
    // Response checking
    //////////////////////////////

    task automatic collect_words();
        int                    waited;
        logic [DATA_WIDTH-1:0] got;
        logic [DATA_WIDTH-1:0] rule;
        string                 verdict;
        for (int k = 0; k < n_tests; k++) begin
            waited = 0;
            @(negedge clk);
            while (!(miso_valid && miso_ready)) begin
                if (waited == TIMEOUT) begin
                    abort_run("timeout waiting for a word on the miso stream");
                end
                @(negedge clk);
                waited++;
            end
            got  = miso_data;
            rule = top_bits(tx_words[k], int'(cmds[k].xfer_len));
            assert (got == exp_words[k]) else begin
                $display("Fail miso_data test %0d: got %h, expected %h", k, got, exp_words[k]);
                note_error(k);
            end
            assert (got == rule) else begin
                $display("Fail miso_data test %0d: got %h, rule gives %h", k, got, rule);
                note_error(k);
            end
            verdict = "ok";
            if (test_errs[k] != 0) begin
                verdict = "FAILED";
            end
            $display("Test %0d: dev %0d cpol %0d cpha %0d len %0d, %s", k, cmds[k].device,
                     cmds[k].cpol, cmds[k].cpha, cmds[k].xfer_len, verdict);
        end
    endtask

    task automatic check_completion();
        int want;
        assert (done_cnt < n_tests) else begin
            $display("Error: cmd_completed pulse with no command outstanding");
            errors++;
        end
        if (done_cnt < n_tests) begin
            want = 2 * int'(cmds[done_cnt].xfer_len);
            assert (edge_cnt == want) else begin
                $display("Fail sclk edges test %0d: got %h, expected %h", done_cnt, edge_cnt,
                         want);
                note_error(done_cnt);
            end
            assert (sclk == cmds[done_cnt].cpol) else begin
                $display("Fail sclk test %0d: got %h, expected %h", done_cnt, sclk,
                         cmds[done_cnt].cpol);
                note_error(done_cnt);
            end
        end
        done_cnt++;
        edge_cnt = 0;
    endtask

    // Select lines, SCLK edges and completions
    always @(negedge clk) begin
        if (rstn) begin
            if (sel_active) begin
                if (done_cnt < n_tests) begin
                    assert (csn == exp_sels[done_cnt]) else begin
                        $display("Fail csn test %0d: got %h, expected %h", done_cnt, csn,
                                 exp_sels[done_cnt]);
                        note_error(done_cnt);
                    end
                end
                if (sclk != prev_sclk) begin
                    edge_cnt++;
                end
            end else begin
                assert (csn == '0) else begin
                    $display("Fail csn: got %h, expected %h while deselected", csn, 8'h00);
                    errors++;
                end
            end
            if (cmd_completed) begin
                check_completion();
            end
        end
        prev_sclk = sclk;
    end

    initial begin
        int failed_tests;
        int waited;
        clk        = 1'b0;
        rstn       = 1'b0;
        cmd_valid  = 1'b0;
        cmd_data   = '0;
        mosi_valid = 1'b0;
        mosi_data  = '0;
        miso_ready = 1'b0;
        errors     = 0;
        done_cnt   = 0;
        edge_cnt   = 0;
        prev_sclk  = 1'b0;
        void'($urandom(32'he8f2_ba11));
        load_tests();
        if (n_tests == 0) begin
            abort_run("no tests found in verif/spi_input.txt");
        end
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;
        fork
            drive_cmds();
            drive_words();
            collect_words();
        join
        waited = 0;
        while (engine_busy || done_cnt < n_tests) begin
            if (waited == TIMEOUT) begin
                abort_run("timeout waiting for the engine to go idle");
            end
            @(negedge clk);
            waited++;
        end
        // Room for any stray completion
        repeat (10) @(negedge clk);
        assert (done_cnt == n_tests) else begin
            $display("Fail cmd_completed count: got %h, expected %h", done_cnt, n_tests);
            errors++;
        end
        assert (!engine_busy) else begin
            $display("Fail engine_busy: got %h, expected %h", engine_busy, 1'b0);
            errors++;
        end
        failed_tests = 0;
        foreach (test_errs[k]) begin
            if (test_errs[k] != 0) begin
                failed_tests++;
            end
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", n_tests,
                 n_tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
